/* verilog.f */
hdl/gsau_pkg.sv
hdl/gsau_fifo.sv
hdl/gsau_issue.sv
hdl/gsau_mac_array.sv
hdl/gsau_writeback.sv
hdl/gsau_top.sv
tests/tb_gsau.sv

/* Makefile */
TOOL   = verilator
FLAGS  = --binary --timing -Wno-fatal
TOP    = tb_gsau
FLIST  = verilog.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'TEST OK' $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tests/tb_gsau.sv */
`timescale 1ns/10ps

module tb_gsau import gsau_pkg::*; ();

  // --------------------------------------------------------------------------
  // run length
  // --------------------------------------------------------------------------

  localparam int N_CMP2     = 40;
  localparam int N_MIX3     = 200;
  localparam int N_MIX4     = 200;
  localparam int TOTAL_OPS  = 4 + N_CMP2 + N_MIX3 + N_MIX4 + OP_DEPTH;
  localparam int MAX_CYCLES = 40 * TOTAL_OPS + 1000;

  logic              CLK;
  logic              nRST;
  logic              sb_valid;
  op_t               sb_op;
  logic              sb_ready;
  logic              veg_valid;
  vec_t              veg_vdata;
  logic              veg_ready;
  logic              wb_valid;
  psum_vec_t         wb_psum;
  logic [VDST_W-1:0] wb_vdst;
  logic              wb_ready;

  integer seed          = 78125;
  int     cyc           = 0;
  int     errors        = 0;
  int     results       = 0;
  int     computes      = 0;
  int     first_cmp_cyc = -1;
  int     first_wb_cyc  = -1;

  // ops of the reference model still waiting for a vector
  op_t               pend_q[$];
  // weight rows and the next row to overwrite
  vec_t              w_m [LANES];
  int                w_ptr = 0;
  // results owed to the writeback buffer in issue order
  psum_vec_t         exp_psum_q[$];
  logic [VDST_W-1:0] exp_vdst_q[$];
  // output seen while blocked at the previous edge
  logic              held = 1'b0;
  psum_vec_t         held_psum;
  logic [VDST_W-1:0] held_vdst;

  gsau_top u_gsau_top (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int i = 0; i < LANES; i++) begin
      v[i] = DATA_W'($random(seed));
    end
    return v;
  endfunction

  // lane j is the sum over i of element i times row i lane j
  function automatic psum_vec_t expect_product(vec_t v);
    psum_vec_t r;
    int        acc;
    for (int j = 0; j < LANES; j++) begin
      acc = 0;
      for (int i = 0; i < LANES; i++) begin
        acc += int'(v[i]) * int'(w_m[i][j]);
      end
      r[j] = PSUM_W'(acc);
    end
    return r;
  endfunction

  task automatic log_mismatch(input string name, input logic [$bits(psum_vec_t)-1:0] exp_v,
                              input logic [$bits(psum_vec_t)-1:0] got_v);
    errors++;
    $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp_v, got_v);
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %0d errors", name, errors - err_before);
  endtask

  // --------------------------------------------------------------------------
  // monitor sees the values from just before each edge
  // --------------------------------------------------------------------------

  always @(posedge CLK) begin : monitor
    op_t               op;
    psum_vec_t         e_psum;
    logic [VDST_W-1:0] e_vdst;
    logic              exp_sb_rdy;
    logic              exp_veg_rdy;
    if (nRST) begin
      // ready flags follow the op count and the blocked output
      exp_sb_rdy  = pend_q.size() < OP_DEPTH;
      exp_veg_rdy = (pend_q.size() != 0) && !(wb_valid && !wb_ready);
      if (sb_ready !== exp_sb_rdy) log_mismatch("sb_ready", exp_sb_rdy, sb_ready);
      if (veg_ready !== exp_veg_rdy) log_mismatch("veg_ready", exp_veg_rdy, veg_ready);
      // a blocked result must sit still
      if (held) begin
        if (wb_valid !== 1'b1) log_mismatch("wb_valid", 1'b1, wb_valid);
        if (wb_psum !== held_psum) log_mismatch("wb_psum", held_psum, wb_psum);
        if (wb_vdst !== held_vdst) log_mismatch("wb_vdst", held_vdst, wb_vdst);
      end
      held      = wb_valid && !wb_ready;
      held_psum = wb_psum;
      held_vdst = wb_vdst;
      // each vector takes the oldest op
      if (veg_valid && veg_ready && pend_q.size() != 0) begin
        op = pend_q.pop_front();
        if (op.weight) begin
          w_m[w_ptr] = veg_vdata;
          w_ptr      = (w_ptr + 1) % LANES;
        end else begin
          exp_psum_q.push_back(expect_product(veg_vdata));
          exp_vdst_q.push_back(op.vdst);
          computes++;
          if (first_cmp_cyc < 0) first_cmp_cyc = cyc;
        end
      end
      if (sb_valid && sb_ready) pend_q.push_back(sb_op);
      if (wb_valid && first_wb_cyc < 0) first_wb_cyc = cyc;
      if (wb_valid && wb_ready) begin
        if (exp_psum_q.size() == 0) begin
          errors++;
          $display("result at %0t arrived with no compute outstanding", $time);
        end else begin
          e_psum = exp_psum_q.pop_front();
          e_vdst = exp_vdst_q.pop_front();
          if (wb_psum !== e_psum) log_mismatch("wb_psum", e_psum, wb_psum);
          if (wb_vdst !== e_vdst) log_mismatch("wb_vdst", e_vdst, wb_vdst);
          results++;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  // offers n_sb ops and n_veg vectors where the first n_lead_w ops are weights
  task automatic run_traffic(input int n_sb, input int n_veg, input int n_lead_w,
                             input int unsigned w_pct, input int unsigned sb_pct,
                             input int unsigned veg_pct, input int unsigned wb_pct);
    int  sent;
    int  fed;
    op_t op;
    bit  sb_x;
    bit  veg_x;
    sent = 0;
    fed  = 0;
    while (sent < n_sb || fed < n_veg) begin
      @(posedge CLK);
      sb_x  = sb_valid && sb_ready;
      veg_x = veg_valid && veg_ready;
      if (sb_x) sent++;
      if (veg_x) fed++;
      // an offer stays up until it is taken
      if (sb_x || !sb_valid) begin
        if (sent < n_sb && rand_below(100) < sb_pct) begin
          op.vdst   = VDST_W'($random(seed));
          op.weight = (sent < n_lead_w) || (rand_below(100) < w_pct);
          sb_valid <= 1'b1;
          sb_op    <= op;
        end else begin
          sb_valid <= 1'b0;
        end
      end
      if (veg_x || !veg_valid) begin
        if (fed < n_veg && rand_below(100) < veg_pct) begin
          veg_valid <= 1'b1;
          veg_vdata <= rand_vec();
        end else begin
          veg_valid <= 1'b0;
        end
      end
      wb_ready <= (rand_below(100) < wb_pct);
    end
  endtask

  // let every owed result leave, then open the writeback side
  task automatic drain_results(input int unsigned wb_pct);
    @(posedge CLK);
    // the model has settled by the falling edge
    @(negedge CLK);
    while (exp_psum_q.size() != 0) begin
      @(posedge CLK);
      wb_ready <= (rand_below(100) < wb_pct);
      @(negedge CLK);
    end
    @(posedge CLK);
    wb_ready <= 1'b1;
    @(posedge CLK);
  endtask

  initial begin
    int err0;
    int lat;
    nRST      = 1'b0;
    sb_valid  = 1'b0;
    sb_op     = '0;
    veg_valid = 1'b0;
    veg_vdata = '0;
    wb_ready  = 1'b1;
    foreach (w_m[i]) w_m[i] = '0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;

    err0 = errors;
    @(posedge CLK);
    if (wb_valid !== 1'b0) log_mismatch("wb_valid", 1'b0, wb_valid);
    if (veg_ready !== 1'b0) log_mismatch("veg_ready", 1'b0, veg_ready);
    if (sb_ready !== 1'b1) log_mismatch("sb_ready", 1'b1, sb_ready);
    report_test("test 1 reset state", err0);

    // full weight set, then back to back computes
    err0 = errors;
    run_traffic(4 + N_CMP2, 4 + N_CMP2, 4, 0, 100, 100, 100);
    drain_results(100);
    // wb_valid rises 4 edges after the transfer and is sampled one edge later
    lat = first_wb_cyc - first_cmp_cyc - 1;
    if (lat !== 4) log_mismatch("first result latency", 4, lat);
    report_test("test 2 weights then computes", err0);

    err0 = errors;
    run_traffic(N_MIX3, N_MIX3, 0, 30, 60, 60, 100);
    drain_results(100);
    report_test("test 3 weight reloads", err0);

    // writeback side pushes back half the time
    err0 = errors;
    run_traffic(N_MIX4, N_MIX4, 0, 20, 70, 70, 50);
    drain_results(50);
    // every owed result is out so a second copy would still be showing
    if (wb_valid !== 1'b0) log_mismatch("wb_valid", 1'b0, wb_valid);
    report_test("test 4 writeback back-pressure", err0);

    // op queue fills with no vectors coming
    err0 = errors;
    run_traffic(OP_DEPTH, 0, 0, 50, 100, 0, 100);
    @(posedge CLK);
    if (sb_ready !== 1'b0) log_mismatch("sb_ready", 1'b0, sb_ready);
    run_traffic(0, 1, 0, 0, 0, 100, 100);
    @(posedge CLK);
    if (sb_ready !== 1'b1) log_mismatch("sb_ready", 1'b1, sb_ready);
    run_traffic(0, OP_DEPTH - 1, 0, 0, 0, 100, 100);
    drain_results(100);
    report_test("test 5 op queue full", err0);

    $display("results %0d, computes %0d, errors %0d", results, computes, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* hdl/gsau_top.sv */
`timescale 1ns/10ps

module gsau_top import gsau_pkg::*; (
  input  logic              CLK,
  input  logic              nRST,
  // scoreboard
  input  logic              sb_valid,
  input  op_t               sb_op,
  output logic              sb_ready,
  // veggie
  input  logic              veg_valid,
  input  vec_t              veg_vdata,
  output logic              veg_ready,
  // writeback buffer
  output logic              wb_valid,
  output psum_vec_t         wb_psum,
  output logic [VDST_W-1:0] wb_vdst,
  input  logic              wb_ready
);

  // op queue
  op_t               op_head;
  logic              op_empty;
  logic              op_full;
  logic              op_pop;
  // destination queue
  logic              dst_push;
  logic [VDST_W-1:0] dst_vdst;
  logic [VDST_W-1:0] dst_head;
  logic              dst_empty;
  logic              dst_pop;
  // pipeline
  sa_cmd_t           cmd;
  logic              stall;
  logic              res_valid;
  psum_vec_t         res_psum;

  // scoreboard sees only the queue fill level
  assign sb_ready = !op_full;

  gsau_fifo #(.entry_t(op_t), .DEPTH(OP_DEPTH)) u_op_fifo (
    .CLK(CLK), .nRST(nRST),
    .push(sb_valid && !op_full), .din(sb_op), .pop(op_pop),
    .dout(op_head), .empty(op_empty), .full(op_full)
  );

  gsau_fifo #(.entry_t(logic [VDST_W-1:0]), .DEPTH(DST_DEPTH)) u_dst_fifo (
    .CLK(CLK), .nRST(nRST),
    .push(dst_push), .din(dst_vdst), .pop(dst_pop),
    .dout(dst_head), .empty(dst_empty), .full()
  );

  gsau_issue u_issue (
    .CLK(CLK), .nRST(nRST),
    .op_head(op_head), .op_empty(op_empty), .op_pop(op_pop),
    .veg_valid(veg_valid), .veg_vdata(veg_vdata), .veg_ready(veg_ready),
    .stall(stall), .cmd(cmd), .dst_push(dst_push), .dst_vdst(dst_vdst)
  );

  gsau_mac_array u_mac_array (
    .CLK(CLK), .nRST(nRST), .cmd(cmd), .stall(stall),
    .res_valid(res_valid), .res_psum(res_psum)
  );

  gsau_writeback u_writeback (
    .CLK(CLK), .nRST(nRST),
    .res_valid(res_valid), .res_psum(res_psum),
    .dst_head(dst_head), .dst_empty(dst_empty), .dst_pop(dst_pop),
    .stall(stall),
    .wb_valid(wb_valid), .wb_psum(wb_psum), .wb_vdst(wb_vdst), .wb_ready(wb_ready)
  );

endmodule

/* hdl/gsau_writeback.sv */
`timescale 1ns/10ps

module gsau_writeback import gsau_pkg::*; (
  input  logic              CLK,
  input  logic              nRST,
  // result from the array
  input  logic              res_valid,
  input  psum_vec_t         res_psum,
  // destination queue head
  input  logic [VDST_W-1:0] dst_head,
  input  logic              dst_empty,
  output logic              dst_pop,
  // pipeline hold
  output logic              stall,
  // writeback buffer
  output logic              wb_valid,
  output psum_vec_t         wb_psum,
  output logic [VDST_W-1:0] wb_vdst,
  input  logic              wb_ready
);

  // --------------------------------------------------------------------------
  // output holding register
  // --------------------------------------------------------------------------

  logic              valid_q;
  psum_vec_t         psum_q;
  logic [VDST_W-1:0] vdst_q;
  logic              capture;

  // hold everything upstream while an unsent result is blocked
  assign stall = valid_q && !wb_ready;

  // the register is free whenever it is not blocked
  // so a new result can replace one that leaves on the same edge
  assign capture = res_valid && !stall;

  // the matching destination is always at the queue head
  // since computes push in issue order and finish in issue order
  assign dst_pop = capture && !dst_empty;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (wb_ready) begin
      // sent, nothing new behind it
      valid_q <= 1'b0;
    end
  end

  // payload stays put until the next capture
  always_ff @(posedge CLK) begin
    if (capture) begin
      psum_q <= res_psum;
      vdst_q <= dst_head;
    end
  end

  assign wb_valid = valid_q;
  assign wb_psum  = psum_q;
  assign wb_vdst  = vdst_q;

endmodule

/* hdl/gsau_mac_array.sv */
`timescale 1ns/10ps

module gsau_mac_array import gsau_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  sa_cmd_t   cmd,
  input  logic      stall,
  output logic      res_valid,
  output psum_vec_t res_psum
);

  // --------------------------------------------------------------------------
  // weight storage
  // --------------------------------------------------------------------------

  // row i holds the weights that multiply vector element i
  vec_t                       w_q [LANES];
  logic [$clog2(LANES)-1:0]   row_ptr_q;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < LANES; i++) begin
        w_q[i] <= '0;
      end
      row_ptr_q <= '0;
    end else if (!stall && cmd.load_weight) begin
      w_q[row_ptr_q] <= cmd.data;
      // rows are filled round robin
      row_ptr_q <= (row_ptr_q == ($clog2(LANES))'(LANES - 1)) ? '0 : row_ptr_q + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // compute pipeline
  // --------------------------------------------------------------------------

  // per stage valid bits
  logic v1_q;
  logic v2_q;
  logic v3_q;

  // stage 1 products, stage 2 half sums, stage 3 final sums
  logic [2*DATA_W-1:0] prod_d [LANES][LANES];
  logic [2*DATA_W-1:0] prod_q [LANES][LANES];
  psum_vec_t           lo_d, hi_d;
  psum_vec_t           lo_q, hi_q;
  psum_vec_t           res_d, res_q;

  // element i of the vector against row i lane j
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      for (int j = 0; j < LANES; j++) begin
        prod_d[i][j] = cmd.data[i] * w_q[i][j];
      end
    end
  end

  // split the row sum into two halves to keep the adder chain short
  always_comb begin
    lo_d = '0;
    hi_d = '0;
    for (int j = 0; j < LANES; j++) begin
      for (int i = 0; i < LANES; i++) begin
        if (i < LANES / 2) begin
          lo_d[j] = lo_d[j] + PSUM_W'(prod_q[i][j]);
        end else begin
          hi_d[j] = hi_d[j] + PSUM_W'(prod_q[i][j]);
        end
      end
    end
  end

  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      res_d[j] = lo_q[j] + hi_q[j];
    end
  end

  // valid chain, everything freezes on stall
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
      v3_q <= 1'b0;
    end else if (!stall) begin
      v1_q <= cmd.compute;
      v2_q <= v1_q;
      v3_q <= v2_q;
    end
  end

  // datapath, loaded only when the stage input is valid
  always_ff @(posedge CLK) begin
    if (!stall) begin
      if (cmd.compute) prod_q <= prod_d;
      if (v1_q) begin
        lo_q <= lo_d;
        hi_q <= hi_d;
      end
      if (v2_q) res_q <= res_d;
    end
  end

  assign res_valid = v3_q;
  assign res_psum  = res_q;

endmodule

/* hdl/gsau_issue.sv */
`timescale 1ns/10ps

module gsau_issue import gsau_pkg::*; (
  input  logic              CLK,
  input  logic              nRST,
  // op queue head
  input  op_t               op_head,
  input  logic              op_empty,
  output logic              op_pop,
  // veggie operand stream
  input  logic              veg_valid,
  input  vec_t              veg_vdata,
  output logic              veg_ready,
  // back-pressure from writeback
  input  logic              stall,
  // command into the array
  output sa_cmd_t           cmd,
  // destination queue push
  output logic              dst_push,
  output logic [VDST_W-1:0] dst_vdst
);

  // --------------------------------------------------------------------------
  // veggie pairing
  // --------------------------------------------------------------------------

  logic veg_xfer;
  logic is_weight;

  // a vector is only taken when there is an op waiting for it
  // and the pipeline is free to move
  assign veg_ready = !op_empty && !stall;
  assign veg_xfer  = veg_valid && veg_ready;
  assign is_weight = op_head.weight;

  // every accepted vector consumes exactly one op
  assign op_pop = veg_xfer;

  // computes leave their destination behind in issue order
  // weight loads produce no result so they push nothing
  assign dst_push = veg_xfer && !is_weight;
  assign dst_vdst = op_head.vdst;

  // --------------------------------------------------------------------------
  // command register
  // --------------------------------------------------------------------------

  logic lw_q;
  logic cmp_q;
  vec_t data_q;

  // valid bits, held while stalled
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      lw_q  <= 1'b0;
      cmp_q <= 1'b0;
    end else if (!stall) begin
      lw_q  <= veg_xfer && is_weight;
      cmp_q <= veg_xfer && !is_weight;
    end
  end

  // operand payload only loads on a transfer
  always_ff @(posedge CLK) begin
    if (!stall && veg_xfer) begin
      data_q <= veg_vdata;
    end
  end

  always_comb begin
    cmd.load_weight = lw_q;
    cmd.compute     = cmp_q;
    cmd.data        = data_q;
  end

endmodule

/* hdl/gsau_fifo.sv */
`timescale 1ns/10ps

module gsau_fifo #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 4
) (
  input  logic   CLK,
  input  logic   nRST,
  input  logic   push,
  input  entry_t din,
  input  logic   pop,
  output entry_t dout,
  output logic   empty,
  output logic   full
);

  typedef logic [$clog2(DEPTH)-1:0] ptr_t;
  // one bit wider than the pointers so full and empty differ
  typedef logic [$clog2(DEPTH):0]   cnt_t;

  entry_t mem [DEPTH];
  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  cnt_t   count;

  // requests past the limits are dropped
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // entry storage
  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at DEPTH even when it is not a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head is read straight out of the array
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == cnt_t'(DEPTH));

endmodule

/* hdl/gsau_pkg.sv */
package gsau_pkg;

  // --------------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------------

  // vector lanes, also the number of weight rows
  localparam int LANES = 4;

  // one activation or weight element
  localparam int DATA_W = 8;

  // one result lane, wide enough for LANES unsigned 8x8 products
  localparam int PSUM_W = 20;

  // destination register index into veggie
  localparam int VDST_W = 8;

  // queue depths
  localparam int OP_DEPTH = 16;
  // must cover every compute that can sit between issue and writeback
  localparam int DST_DEPTH = 8;

  // --------------------------------------------------------------------------
  // shared types
  // --------------------------------------------------------------------------

  // operand vector, element i at [i]
  typedef logic [LANES-1:0][DATA_W-1:0] vec_t;

  // result vector, lane j at [j]
  typedef logic [LANES-1:0][PSUM_W-1:0] psum_vec_t;

  // scoreboard operation
  typedef struct packed {
    logic [VDST_W-1:0] vdst;
    logic              weight;
  } op_t;

  // issue to array command
  // load_weight and compute are never both set
  typedef struct packed {
    logic load_weight;
    logic compute;
    vec_t data;
  } sa_cmd_t;

endpackage
